//--- Makefile
TOP := event_accumulator_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "^Test OK$$" run.log

clean:
	rm -rf obj_dir run.log

//--- rtl/accum_pkg.sv
package accum_pkg;

    // Links 0 to 6 are kept; link 7 is the board's own link
    localparam int N_LINKS = 7;

    typedef logic [2:0] link_id_t;

    typedef enum logic {
        REC_HEADER  = 1'b0,
        REC_PAYLOAD = 1'b1
    } rec_kind_e;

    // Shared by both collectors
    typedef enum logic {
        COLLECT = 1'b0,
        DRAIN   = 1'b1
    } bank_state_e;

    // One input word after deinterleave
    typedef struct packed {
        logic [3:0][7:0] bytes;
        logic            phase;
        logic [15:0]     index;
        logic            valid;
    } lane_bytes_t;

    // One output record, header sits in data[31:0]
    typedef struct packed {
        rec_kind_e   kind;
        link_id_t    ident;
        logic        last;
        logic [63:0] data;
    } record_t;

    // Round of the word after this one, assuming no tlast in between
    function automatic logic [15:0] next_round(lane_bytes_t l);
        return l.index + 16'(l.phase);
    endfunction

endpackage

//--- rtl/event_accumulator.sv
`timescale 1ns/1ps

module event_accumulator #(
    parameter int HDR_BYTES = 4,
    parameter int PAY_BYTES = 16
) (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic [31:0]        s_tdata,
    input  logic               s_tvalid,
    output logic               s_tready,
    input  logic               s_tlast,
    output accum_pkg::record_t m_rec,
    output logic               m_valid,
    input  logic               m_ready
);

    accum_pkg::lane_bytes_t lanes;
    accum_pkg::record_t     hdr_rec;
    accum_pkg::record_t     pay_rec;
    logic hdr_valid;
    logic hdr_ready;
    logic hdr_stall;
    logic hdr_full;
    logic pay_valid;
    logic pay_ready;
    logic pay_stall;
    logic pay_full;

    // Input halts while either bank would be overwritten
    assign s_tready = ~(hdr_stall | pay_stall);

    link_deinterleave u_deint (
        .aclk(aclk), .rst_n(rst_n), .s_tdata(s_tdata), .s_tvalid(s_tvalid),
        .s_tlast(s_tlast), .s_tready(s_tready), .lanes(lanes)
    );

    header_collector #(.HDR_BYTES(HDR_BYTES)) u_hdr (
        .aclk(aclk), .rst_n(rst_n), .lanes(lanes), .hdr_rec(hdr_rec),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready), .stall(hdr_stall), .full(hdr_full)
    );

    payload_packer #(.HDR_BYTES(HDR_BYTES), .PAY_BYTES(PAY_BYTES)) u_pay (
        .aclk(aclk), .rst_n(rst_n), .lanes(lanes), .pay_rec(pay_rec),
        .pay_valid(pay_valid), .pay_ready(pay_ready), .stall(pay_stall), .full(pay_full)
    );

    record_merger u_merge (
        .aclk(aclk), .rst_n(rst_n),
        .hdr_rec(hdr_rec), .hdr_valid(hdr_valid), .hdr_ready(hdr_ready), .hdr_full(hdr_full),
        .pay_rec(pay_rec), .pay_valid(pay_valid), .pay_ready(pay_ready), .pay_full(pay_full),
        .m_rec(m_rec), .m_valid(m_valid), .m_ready(m_ready)
    );

endmodule

//--- rtl/header_collector.sv
`timescale 1ns/1ps

module header_collector #(
    parameter int HDR_BYTES = 4
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  accum_pkg::lane_bytes_t lanes,
    output accum_pkg::record_t     hdr_rec,
    output logic                   hdr_valid,
    input  logic                   hdr_ready,
    output logic                   stall,
    output logic                   full
);

    logic [accum_pkg::N_LINKS-1:0][31:0] bank;
    accum_pkg::bank_state_e              state;
    accum_pkg::link_id_t                 drain_link;

    logic        wr_en;
    logic        completing;
    logic        busy;
    logic [15:0] nxt;

    assign wr_en      = lanes.valid && (lanes.index < HDR_BYTES);
    assign completing = wr_en && lanes.phase && (lanes.index == HDR_BYTES - 1);
    assign nxt        = accum_pkg::next_round(lanes);

    // An odd payload word may carry tlast, so the word after it may be a header
    assign busy  = (state == accum_pkg::DRAIN) || completing;
    assign stall = busy && ((nxt < HDR_BYTES) || (lanes.phase && lanes.index >= HDR_BYTES));

    for (genvar l = 0; l < accum_pkg::N_LINKS; l++) begin : g_link
        always_ff @(posedge aclk) begin
            if (wr_en && lanes.phase == 1'(l / 4)) begin
                bank[l][8*lanes.index[1:0] +: 8] <= lanes.bytes[l % 4];
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= accum_pkg::COLLECT;
            drain_link <= '0;
        end else begin
            case (state)
                accum_pkg::COLLECT: begin
                    if (completing) begin
                        state      <= accum_pkg::DRAIN;
                        drain_link <= '0;
                    end
                end
                default: begin
                    if (hdr_ready) begin
                        if (drain_link == accum_pkg::link_id_t'(accum_pkg::N_LINKS - 1)) begin
                            state <= accum_pkg::COLLECT;
                        end else begin
                            drain_link <= drain_link + 3'd1;
                        end
                    end
                end
            endcase
        end
    end

    assign full      = (state == accum_pkg::DRAIN);
    assign hdr_valid = full;
    assign hdr_rec   = '{kind: accum_pkg::REC_HEADER, ident: drain_link, last: 1'b0,
                         data: {32'd0, bank[drain_link]}};

endmodule

//--- rtl/link_deinterleave.sv
`timescale 1ns/1ps

module link_deinterleave (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic [31:0]            s_tdata,
    input  logic                   s_tvalid,
    input  logic                   s_tlast,
    input  logic                   s_tready,
    output accum_pkg::lane_bytes_t lanes
);

    // Tag for the next word to arrive
    logic        phase_q;
    logic [15:0] index_q;

    // Registered word and the tag it was taken with
    logic [31:0] word_q;
    logic        word_phase_q;
    logic [15:0] word_index_q;
    logic        valid_q;

    logic        accept;

    assign accept = s_tvalid && s_tready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q      <= 1'b0;
            index_q      <= '0;
            word_phase_q <= 1'b0;
            word_index_q <= '0;
            valid_q      <= 1'b0;
        end else begin
            valid_q <= accept;
            if (accept) begin
                word_phase_q <= phase_q;
                word_index_q <= index_q;
                if (s_tlast) begin
                    phase_q <= 1'b0;
                    index_q <= '0;
                end else begin
                    phase_q <= ~phase_q;
                    // A round is complete after its odd word
                    if (phase_q) begin
                        index_q <= index_q + 16'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            word_q <= s_tdata;
        end
    end

    // Tag fields hold between words so collectors can look ahead
    assign lanes = '{bytes: word_q, phase: word_phase_q, index: word_index_q, valid: valid_q};

endmodule

//--- rtl/payload_packer.sv
`timescale 1ns/1ps

module payload_packer #(
    parameter int HDR_BYTES = 4,
    parameter int PAY_BYTES = 16
) (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  accum_pkg::lane_bytes_t lanes,
    output accum_pkg::record_t     pay_rec,
    output logic                   pay_valid,
    input  logic                   pay_ready,
    output logic                   stall,
    output logic                   full
);

    localparam int N_GROUPS = PAY_BYTES / 8;
    localparam int PAY_END  = HDR_BYTES + PAY_BYTES;

    logic [accum_pkg::N_LINKS-1:0][63:0] bank;
    accum_pkg::bank_state_e              state;
    accum_pkg::link_id_t                 drain_link;
    logic                                last_grp;

    logic        wr_en;
    logic        completing;
    logic        final_grp;
    logic        busy;
    logic [15:0] pay_pos;
    logic [15:0] nxt;

    // Byte position within the payload, low three bits pick the byte in the word
    assign pay_pos    = lanes.index - 16'(HDR_BYTES);
    assign wr_en      = lanes.valid && (lanes.index >= HDR_BYTES) && (lanes.index < PAY_END);
    assign completing = wr_en && lanes.phase && (pay_pos[2:0] == 3'd7);
    assign final_grp  = (pay_pos[15:3] == 13'(N_GROUPS - 1));

    // A following word after tlast is a header and never lands here
    assign nxt   = accum_pkg::next_round(lanes);
    assign busy  = (state == accum_pkg::DRAIN) || completing;
    assign stall = busy && (nxt >= HDR_BYTES) && (nxt < PAY_END);

    for (genvar l = 0; l < accum_pkg::N_LINKS; l++) begin : g_link
        always_ff @(posedge aclk) begin
            if (wr_en && lanes.phase == 1'(l / 4)) begin
                bank[l][8*pay_pos[2:0] +: 8] <= lanes.bytes[l % 4];
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= accum_pkg::COLLECT;
            drain_link <= '0;
            last_grp   <= 1'b0;
        end else begin
            case (state)
                accum_pkg::COLLECT: begin
                    if (completing) begin
                        state      <= accum_pkg::DRAIN;
                        drain_link <= '0;
                        last_grp   <= final_grp;
                    end
                end
                default: begin
                    if (pay_ready) begin
                        if (drain_link == accum_pkg::link_id_t'(accum_pkg::N_LINKS - 1)) begin
                            state <= accum_pkg::COLLECT;
                        end else begin
                            drain_link <= drain_link + 3'd1;
                        end
                    end
                end
            endcase
        end
    end

    assign full      = (state == accum_pkg::DRAIN);
    assign pay_valid = full;

    // Event ends on the link 6 word of the final group
    assign pay_rec = '{kind: accum_pkg::REC_PAYLOAD, ident: drain_link,
                       last: last_grp &&
                             (drain_link == accum_pkg::link_id_t'(accum_pkg::N_LINKS - 1)),
                       data: bank[drain_link]};

endmodule

//--- rtl/record_merger.sv
`timescale 1ns/1ps

module record_merger (
    input  logic               aclk,
    input  logic               rst_n,
    input  accum_pkg::record_t hdr_rec,
    input  logic               hdr_valid,
    output logic               hdr_ready,
    input  logic               hdr_full,
    input  accum_pkg::record_t pay_rec,
    input  logic               pay_valid,
    output logic               pay_ready,
    input  logic               pay_full,
    output accum_pkg::record_t m_rec,
    output logic               m_valid,
    input  logic               m_ready
);

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        GRANT_HDR = 2'd1,
        GRANT_PAY = 2'd2
    } grant_e;

    grant_e             grant;
    accum_pkg::record_t sel_rec;
    logic               out_free;
    logic               hdr_take;
    logic               pay_take;
    logic               last_link;

    assign out_free  = !m_valid || m_ready;
    assign hdr_ready = (grant == GRANT_HDR) && out_free;
    assign pay_ready = (grant == GRANT_PAY) && out_free;
    assign hdr_take  = hdr_valid && hdr_ready;
    assign pay_take  = pay_valid && pay_ready;
    assign sel_rec   = (grant == GRANT_PAY) ? pay_rec : hdr_rec;
    assign last_link = (sel_rec.ident == accum_pkg::link_id_t'(accum_pkg::N_LINKS - 1));

    // A bank keeps the grant until its link 6 record is taken
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= IDLE;
        end else begin
            case (grant)
                GRANT_HDR: begin
                    if (hdr_take && last_link) begin
                        grant <= pay_full ? GRANT_PAY : IDLE;
                    end
                end
                GRANT_PAY: begin
                    if (pay_take && last_link) begin
                        grant <= hdr_full ? GRANT_HDR : IDLE;
                    end
                end
                default: begin
                    // Header wins a tie
                    if (hdr_full) begin
                        grant <= GRANT_HDR;
                    end else if (pay_full) begin
                        grant <= GRANT_PAY;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (hdr_take || pay_take) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (hdr_take || pay_take) begin
            m_rec <= sel_rec;
        end
    end

endmodule

//--- verif/event_accumulator_assertions.sv
`timescale 1ns/1ps

module event_accumulator_assertions (
    input logic               aclk,
    input logic               rst_n,
    input accum_pkg::record_t m_rec,
    input logic               m_valid,
    input logic               m_ready,
    input logic               s_tready,
    input logic               hdr_full,
    input logic               pay_full
);

    // A record waiting on m_ready stays put
    assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_rec))
        else $error("m_rec changed or dropped while m_ready was low");

    assert property (@(posedge aclk) !rst_n |-> !m_valid)
        else $error("m_valid high during reset");

    // With both banks free, input only halts on the word that fills one of them
    assert property (@(posedge aclk) disable iff (!rst_n)
        !hdr_full && !pay_full && !s_tready |=> hdr_full || pay_full)
        else $error("s_tready low with both banks empty and none about to fill");

endmodule

bind event_accumulator event_accumulator_assertions u_assertions (
    .aclk(aclk), .rst_n(rst_n), .m_rec(m_rec), .m_valid(m_valid), .m_ready(m_ready),
    .s_tready(s_tready), .hdr_full(hdr_full), .pay_full(pay_full)
);

//--- verif/event_accumulator_tb.sv
`timescale 1ns/1ps

module event_accumulator_tb;

    localparam int HDR_BYTES   = 4;
    localparam int PAY_BYTES   = 16;
    localparam int ROUNDS      = HDR_BYTES + PAY_BYTES;
    localparam int N_EVENTS    = 8;
    localparam int CYCLE_LIMIT = N_EVENTS * 2 * ROUNDS * 4 + 500;

    logic               aclk;
    logic               rst_n;
    logic [31:0]        s_tdata;
    logic               s_tvalid;
    logic               s_tready;
    logic               s_tlast;
    accum_pkg::record_t m_rec;
    logic               m_valid;
    logic               m_ready;

    logic [15:0]        lfsr_state;
    logic [32:0]        word_q[$];
    accum_pkg::record_t exp_q[$];
    accum_pkg::record_t exp_rec;
    logic               ready_fell;
    int                 errors;
    int                 tests_failed;
    int                 total_checked;
    int                 n_hdr;
    int                 n_pay;
    int                 n_last;
    int                 cycle_count;

    event_accumulator #(.HDR_BYTES(HDR_BYTES), .PAY_BYTES(PAY_BYTES)) uut (.*);

    always #4 aclk = ~aclk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic build_event();
        logic [7:0]         b [8][ROUNDS];
        logic [31:0]        w;
        accum_pkg::record_t r;
        for (int l = 0; l < 8; l++) begin
            for (int k = 0; k < ROUNDS; k++) begin
                b[l][k] = 8'(take_bits(8));
            end
        end
        // Even word carries links 0 to 3, odd word links 4 to 7
        for (int k = 0; k < ROUNDS; k++) begin
            for (int h = 0; h < 2; h++) begin
                for (int j = 0; j < 4; j++) begin
                    w[8*j +: 8] = b[4*h + j][k];
                end
                word_q.push_back({(k == ROUNDS - 1) && (h == 1), w});
            end
        end
        for (int l = 0; l < accum_pkg::N_LINKS; l++) begin
            r = '{kind: accum_pkg::REC_HEADER, ident: 3'(l), last: 1'b0, data: '0};
            for (int k = 0; k < HDR_BYTES; k++) begin
                r.data[8*k +: 8] = b[l][k];
            end
            exp_q.push_back(r);
        end
        for (int g = 0; g < PAY_BYTES / 8; g++) begin
            for (int l = 0; l < accum_pkg::N_LINKS; l++) begin
                r.kind  = accum_pkg::REC_PAYLOAD;
                r.ident = 3'(l);
                r.last  = (g == PAY_BYTES / 8 - 1) && (l == accum_pkg::N_LINKS - 1);
                for (int j = 0; j < 8; j++) begin
                    r.data[8*j +: 8] = b[l][HDR_BYTES + 8*g + j];
                end
                exp_q.push_back(r);
            end
        end
    endtask

    // Gap and stall levels are out of 8; m_ready is held low for the first hold cycles
    task automatic run_events(input int n_events, input int gap_level,
                              input int stall_level, input int hold_cycles);
        int   held;
        logic fire;
        held = 0;
        for (int e = 0; e < n_events; e++) begin
            build_event();
        end
        while (word_q.size() > 0 || exp_q.size() > 0) begin
            if (!s_tvalid && word_q.size() > 0 && take_bits(3) >= gap_level) begin
                s_tdata  = word_q[0][31:0];
                s_tlast  = word_q[0][32];
                s_tvalid = 1'b1;
            end
            if (held < hold_cycles) begin
                m_ready = 1'b0;
                held++;
            end else begin
                m_ready = (take_bits(3) >= stall_level);
            end
            @(negedge aclk);
            fire = s_tvalid && s_tready;
            @(posedge aclk);
            #1;
            if (fire) begin
                void'(word_q.pop_front());
                s_tvalid = 1'b0;
                s_tlast  = 1'b0;
            end
        end
    endtask

    task automatic clear_counts();
        n_hdr      = 0;
        n_pay      = 0;
        n_last     = 0;
        ready_fell = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %-20s pass, %0d records", num, name, n_hdr + n_pay);
        end else begin
            tests_failed++;
            $display("test %0d %-20s fail, %0d errors", num, name, errors - errs_before);
        end
    endtask

    // Handshake seen at the falling edge completes on the next rising edge
    always @(negedge aclk) begin
        if (rst_n && m_valid && m_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("Record for link %0d arrived with none expected", m_rec.ident);
                errors++;
            end
            assert (m_rec.ident != 3'd7) else begin
                $display("FAIL m_rec.ident expected not 7 got %h", m_rec.ident);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_rec = exp_q.pop_front();
                assert (m_rec === exp_rec) else begin
                    $display("FAIL m_rec expected %h got %h", exp_rec, m_rec);
                    errors++;
                end
            end
            total_checked++;
            if (m_rec.kind == accum_pkg::REC_HEADER) begin
                n_hdr++;
            end else begin
                n_pay++;
            end
            if (m_rec.last) begin
                n_last++;
            end
        end
        if (rst_n && s_tvalid && !s_tready) begin
            ready_fell = 1'b1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d words unsent, %0d records outstanding",
                 cycle_count, word_q.size(), exp_q.size());
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int errs_before;
        aclk          = 1'b0;
        rst_n         = 1'b0;
        s_tdata       = '0;
        s_tvalid      = 1'b0;
        s_tlast       = 1'b0;
        m_ready       = 1'b0;
        lfsr_state    = 16'd12;
        errors        = 0;
        tests_failed  = 0;
        total_checked = 0;
        clear_counts();
        repeat (8) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        errs_before = errors;
        @(negedge aclk);
        assert (m_valid == 1'b0) else begin
            $display("FAIL m_valid expected 0 got %h", m_valid);
            errors++;
        end
        assert (s_tready == 1'b1) else begin
            $display("FAIL s_tready expected 1 got %h", s_tready);
            errors++;
        end
        report_test(1, "reset_state", errs_before);
        @(posedge aclk);
        #1;

        clear_counts();
        errs_before = errors;
        run_events(1, 0, 0, 0);
        assert (n_hdr == accum_pkg::N_LINKS) else begin
            $display("FAIL header count expected %h got %h", accum_pkg::N_LINKS, n_hdr);
            errors++;
        end
        report_test(2, "single_event_headers", errs_before);

        clear_counts();
        errs_before = errors;
        run_events(1, 0, 0, 0);
        assert (n_last == 1) else begin
            $display("FAIL last count expected 1 got %h", n_last);
            errors++;
        end
        report_test(3, "single_event_payload", errs_before);

        clear_counts();
        errs_before = errors;
        run_events(3, 0, 4, 0);
        report_test(4, "back_to_back_stalls", errs_before);

        clear_counts();
        errs_before = errors;
        run_events(3, 2, 3, 80);
        assert (ready_fell) else begin
            $display("s_tready never fell while m_ready was held low");
            errors++;
        end
        report_test(5, "gaps_and_long_hold", errs_before);

        $display("Tests run: 5, failed: %0d, records checked: %0d, errors: %0d",
                 tests_failed, total_checked, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/accum_pkg.sv
rtl/link_deinterleave.sv
rtl/header_collector.sv
rtl/payload_packer.sv
rtl/record_merger.sv
rtl/event_accumulator.sv
verif/event_accumulator_assertions.sv
verif/event_accumulator_tb.sv
